// ==== led_pkg.sv ====
// shared definitions for the HUB75 LED matrix driver
// panel geometry defaults, pixel format and command opcodes
package led_pkg;

    localparam int BRIGHTNESS_BITS = 2; // bits per channel, one plane each

    // red in the top bits, blue in the bottom bits
    typedef struct packed {
        logic [BRIGHTNESS_BITS-1:0] r;
        logic [BRIGHTNESS_BITS-1:0] g;
        logic [BRIGHTNESS_BITS-1:0] b;
    } pixel_t;

    // command opcodes
    localparam logic [7:0] CMD_PIXEL      = 8'h50; // 'P' x y colour
    localparam logic [7:0] CMD_BRIGHTNESS = 8'h42; // 'B' plane mask
    localparam logic [7:0] CMD_RGB_ENABLE = 8'h45; // 'E' channel mask

    // top level defaults
    localparam int DEFAULT_COLS           = 64;
    localparam int DEFAULT_ROWS           = 32;
    localparam int DEFAULT_TICKS_PER_BIT  = 9;
    localparam int DEFAULT_BASE_ON_CYCLES = 4;

endpackage

// ==== fb_port_if.sv ====
// one client port of the shared framebuffer
interface fb_port_if import led_pkg::*; #(
    parameter int ADDR_W = 11
);
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    pixel_t            wdata;
    logic              gnt;   // one cycle, ends the request
    pixel_t            rdata; // valid the cycle after gnt

    modport client (output req, we, addr, wdata, input gnt, rdata);
    modport memory (input req, we, addr, wdata, output gnt, rdata);
endinterface

// ==== pixel_load_if.sv ====
// column load handshake between the scan engine and the pixel fetch unit
interface pixel_load_if import led_pkg::*; #(
    parameter int COL_W = 6,
    parameter int ROW_W = 4
);
    logic             load;   // one cycle pulse
    logic [COL_W-1:0] col;    // held until done
    logic [ROW_W-1:0] row;    // row within the top half
    logic             done;   // one cycle pulse
    pixel_t           top;
    pixel_t           bottom; // row + ROWS/2

    modport scan  (output load, col, row, input done, top, bottom);
    modport fetch (input load, col, row, output done, top, bottom);
endinterface

// ==== uart_rx.sv ====
// UART receiver, 8N1
// two-flop synchroniser, mid-bit sampling, frames with a bad stop bit dropped
module uart_rx import led_pkg::*; #(
    parameter int TICKS_PER_BIT = DEFAULT_TICKS_PER_BIT
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] byte_data,
    output logic       byte_valid
);
    localparam int CNT_W = $clog2(TICKS_PER_BIT + 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t           state;
    logic [1:0]       sync_q;   // [1] is the usable line
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            sync_q     <= 2'b11; // line idles high
            state      <= S_IDLE;
            tick_cnt   <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            sync_q     <= {sync_q[0], rxd};
            byte_valid <= 1'b0;
            if (tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (!sync_q[1]) begin
                        // wait half a bit to land mid start bit
                        tick_cnt <= CNT_W'(TICKS_PER_BIT / 2 - 1);
                        state    <= S_START;
                    end
                end
                S_START: begin
                    if (tick_cnt == '0) begin
                        tick_cnt <= CNT_W'(TICKS_PER_BIT - 1);
                        bit_idx  <= '0;
                        state    <= sync_q[1] ? S_IDLE : S_DATA; // glitch filter
                    end
                end
                S_DATA: begin
                    if (tick_cnt == '0) begin
                        shift_q  <= {sync_q[1], shift_q[7:1]}; // lsb first
                        bit_idx  <= bit_idx + 1'b1;
                        tick_cnt <= CNT_W'(TICKS_PER_BIT - 1);
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                        end
                    end
                end
                default: begin
                    if (tick_cnt == '0) begin
                        if (sync_q[1]) begin
                            byte_data  <= shift_q;
                            byte_valid <= 1'b1;
                        end
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end
endmodule

// ==== cmd_decoder.sv ====
// command decoder
// parses received bytes into framebuffer writes and display mask registers
module cmd_decoder import led_pkg::*; #(
    parameter int COLS = DEFAULT_COLS,
    parameter int ROWS = DEFAULT_ROWS
) (
    input  logic                       clk_root,
    input  logic                       rst_n,
    input  logic [7:0]                 byte_data,
    input  logic                       byte_valid,
    fb_port_if.client                  wr_port,
    output logic [2:0]                 rgb_enable,       // {r, g, b}
    output logic [BRIGHTNESS_BITS-1:0] brightness_enable // one bit per plane
);
    localparam int ADDR_W = $clog2(COLS * ROWS);

    typedef enum logic [2:0] {
        S_OPCODE, S_PIX_X, S_PIX_Y, S_PIX_COLOR, S_BRT_ARG, S_RGB_ARG
    } state_t;

    state_t     state;
    logic [7:0] x_q;
    logic [7:0] y_q;
    logic       in_range;

    assign in_range   = (x_q < COLS) && (y_q < ROWS);
    assign wr_port.we = 1'b1; // this port only ever writes

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state             <= S_OPCODE;
            wr_port.req       <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            if (wr_port.gnt) begin
                wr_port.req <= 1'b0;
            end
            if (byte_valid) begin
                case (state)
                    S_OPCODE: begin
                        case (byte_data)
                            CMD_PIXEL:      state <= S_PIX_X;
                            CMD_BRIGHTNESS: state <= S_BRT_ARG;
                            CMD_RGB_ENABLE: state <= S_RGB_ARG;
                            default:        state <= S_OPCODE; // unknown, skip
                        endcase
                    end
                    S_PIX_X: state <= S_PIX_Y;
                    S_PIX_Y: state <= S_PIX_COLOR;
                    S_PIX_COLOR: begin
                        // off-panel pixels are consumed but never written
                        if (in_range) begin
                            wr_port.req <= 1'b1;
                        end
                        state <= S_OPCODE;
                    end
                    S_BRT_ARG: begin
                        brightness_enable <= byte_data[BRIGHTNESS_BITS-1:0];
                        state             <= S_OPCODE;
                    end
                    default: begin
                        rgb_enable <= byte_data[2:0];
                        state      <= S_OPCODE;
                    end
                endcase
            end
        end
    end

    // argument and write payload
    always_ff @(posedge clk_root) begin
        if (byte_valid && state == S_PIX_X) begin
            x_q <= byte_data;
        end
        if (byte_valid && state == S_PIX_Y) begin
            y_q <= byte_data;
        end
        if (byte_valid && state == S_PIX_COLOR) begin
            wr_port.addr  <= ADDR_W'(y_q * COLS + x_q); // row major
            wr_port.wdata <= byte_data[$bits(pixel_t)-1:0];
        end
    end

    // full address before truncation, held while the write waits
    a_wr_in_range: assert property (@(posedge clk_root) disable iff (!rst_n)
        wr_port.req |-> int'(y_q) * COLS + int'(x_q) < COLS * ROWS);
endmodule

// ==== framebuffer.sv ====
// single-port pixel memory shared by two clients
// fixed-priority arbiter, the read port wins a conflict
module framebuffer import led_pkg::*; #(
    parameter int COLS = DEFAULT_COLS,
    parameter int ROWS = DEFAULT_ROWS
) (
    input  logic       clk_root,
    input  logic       rst_n,
    fb_port_if.memory  wr_port,
    fb_port_if.memory  rd_port
);
    localparam int DEPTH  = COLS * ROWS;
    localparam int ADDR_W = $clog2(DEPTH);

    pixel_t            mem [DEPTH];
    logic              acc_en;
    logic              acc_we;
    logic [ADDR_W-1:0] acc_addr;
    pixel_t            acc_wdata;
    pixel_t            rdata_q;

    // grant in the request cycle, the writer waits while the reader asks
    assign rd_port.gnt = rd_port.req;
    assign wr_port.gnt = wr_port.req & ~rd_port.req;

    assign acc_en    = rd_port.req | wr_port.req;
    assign acc_we    = rd_port.req ? rd_port.we    : wr_port.we;
    assign acc_addr  = rd_port.req ? rd_port.addr  : wr_port.addr;
    assign acc_wdata = rd_port.req ? rd_port.wdata : wr_port.wdata;

    always_ff @(posedge clk_root) begin
        if (acc_en) begin
            if (acc_we) begin
                mem[acc_addr] <= acc_wdata;
            end
            rdata_q <= mem[acc_addr]; // read-before-write
        end
    end

    assign rd_port.rdata = rdata_q;
    assign wr_port.rdata = rdata_q;

    // a blocked writer holds its request and is served next cycle
    a_wr_served: assert property (@(posedge clk_root) disable iff (!rst_n)
        (wr_port.req && !wr_port.gnt) |=>
            wr_port.gnt && $stable(wr_port.addr) && $stable(wr_port.wdata));
    // reader leaves a free cycle after each grant
    a_rd_gap: assert property (@(posedge clk_root) disable iff (!rst_n)
        rd_port.gnt |=> !rd_port.req);
endmodule

// ==== pixel_fetch.sv ====
// pixel fetch unit
// reads the top and bottom half pixels of one column through the arbiter
module pixel_fetch import led_pkg::*; #(
    parameter int COLS = DEFAULT_COLS,
    parameter int ROWS = DEFAULT_ROWS
) (
    input  logic       clk_root,
    input  logic       rst_n,
    pixel_load_if.fetch scan,
    fb_port_if.client  rd_port
);
    localparam int ADDR_W = $clog2(COLS * ROWS);

    typedef enum logic [2:0] {
        S_IDLE, S_RD_TOP, S_WAIT_TOP, S_RD_BOT, S_WAIT_BOT
    } state_t;

    state_t            state;
    logic [ADDR_W-1:0] top_addr;
    pixel_t            top_q;

    assign top_addr = ADDR_W'(scan.row * COLS + scan.col);

    // the gap after each grant leaves the writer a free cycle
    assign rd_port.req   = (state == S_RD_TOP) || (state == S_RD_BOT);
    assign rd_port.we    = 1'b0;
    assign rd_port.wdata = '0;
    assign rd_port.addr  = (state == S_RD_BOT) ?
                           top_addr + ADDR_W'(ROWS / 2 * COLS) : top_addr;

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:     if (scan.load) state <= S_RD_TOP;
                S_RD_TOP:   if (rd_port.gnt) state <= S_WAIT_TOP;
                S_WAIT_TOP: state <= S_RD_BOT;
                S_RD_BOT:   if (rd_port.gnt) state <= S_WAIT_BOT;
                default:    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_root) begin
        if (state == S_WAIT_TOP) begin
            top_q <= rd_port.rdata;
        end
    end

    assign scan.done   = (state == S_WAIT_BOT);
    assign scan.top    = top_q;
    assign scan.bottom = rd_port.rdata; // second read lands with done
endmodule

// ==== matrix_scan.sv ====
// HUB75 scan engine
// column shift, row latch and binary-weighted output enable per bit plane
module matrix_scan import led_pkg::*; #(
    parameter int COLS           = DEFAULT_COLS,
    parameter int ROWS           = DEFAULT_ROWS,
    parameter int BASE_ON_CYCLES = DEFAULT_BASE_ON_CYCLES
) (
    input  logic                       clk_root,
    input  logic                       rst_n,
    pixel_load_if.scan                 fetch,
    input  logic [2:0]                 rgb_enable,
    input  logic [BRIGHTNESS_BITS-1:0] brightness_enable,
    output logic [2:0]                 rgb_top,
    output logic [2:0]                 rgb_bottom,
    output logic [$clog2(ROWS/2)-1:0]  row_addr,
    output logic                       pixel_clk,
    output logic                       row_latch,
    output logic                       output_enable_n
);
    localparam int COL_W   = $clog2(COLS);
    localparam int ROW_W   = $clog2(ROWS / 2);
    localparam int PLANE_W = (BRIGHTNESS_BITS > 1) ? $clog2(BRIGHTNESS_BITS) : 1;
    localparam int ON_W    = $clog2((BASE_ON_CYCLES << (BRIGHTNESS_BITS - 1)) + 1);

    typedef enum logic [2:0] {
        S_LOAD, S_WAIT, S_SETUP, S_CLK, S_ADDR, S_LATCH, S_ON
    } state_t;

    state_t             state;
    logic [COL_W-1:0]   col_q;
    logic [ROW_W-1:0]   row_q;
    logic [PLANE_W-1:0] plane_q;
    logic [ON_W-1:0]    on_cnt;

    // current plane bit of each channel, gated by both masks
    function automatic logic [2:0] plane_bits(pixel_t px);
        logic plane_on;
        plane_on = brightness_enable[plane_q];
        return {px.r[plane_q], px.g[plane_q], px.b[plane_q]} & rgb_enable & {3{plane_on}};
    endfunction

    always_ff @(posedge clk_root) begin
        if (!rst_n) begin
            state    <= S_LOAD;
            col_q    <= '0;
            row_q    <= '0;
            plane_q  <= '0;
            on_cnt   <= '0;
            row_addr <= '0;
        end else begin
            case (state)
                S_LOAD:  state <= S_WAIT;
                S_WAIT:  if (fetch.done) state <= S_SETUP; // stall until pixels arrive
                S_SETUP: state <= S_CLK;
                S_CLK: begin
                    if (col_q == COL_W'(COLS - 1)) begin
                        col_q    <= '0;
                        row_addr <= row_q; // settles while OE is still off
                        state    <= S_ADDR;
                    end else begin
                        col_q <= col_q + 1'b1;
                        state <= S_LOAD;
                    end
                end
                S_ADDR: state <= S_LATCH;
                S_LATCH: begin
                    on_cnt <= ON_W'((BASE_ON_CYCLES << plane_q) - 1);
                    state  <= S_ON;
                end
                default: begin
                    if (on_cnt != '0) begin
                        on_cnt <= on_cnt - 1'b1;
                    end else begin
                        state <= S_LOAD;
                        if (plane_q == PLANE_W'(BRIGHTNESS_BITS - 1)) begin
                            plane_q <= '0;
                            row_q   <= (row_q == ROW_W'(ROWS / 2 - 1)) ? '0 : row_q + 1'b1;
                        end else begin
                            plane_q <= plane_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // shift data, held through the pixel clock cycle
    always_ff @(posedge clk_root) begin
        if (state == S_WAIT && fetch.done) begin
            rgb_top    <= plane_bits(fetch.top);
            rgb_bottom <= plane_bits(fetch.bottom);
        end
    end

    assign fetch.load      = (state == S_LOAD);
    assign fetch.col       = col_q;
    assign fetch.row       = row_q;
    assign pixel_clk       = (state == S_CLK);
    assign row_latch       = (state == S_LATCH);
    assign output_enable_n = (state != S_ON);

    // fetch answers only a pending load
    a_done_in_wait: assert property (@(posedge clk_root) disable iff (!rst_n)
        fetch.done |-> state == S_WAIT);
endmodule

// ==== led_matrix_top.sv ====
// LED matrix driver top level
// UART commands into a shared framebuffer, HUB75 scan out
module led_matrix_top import led_pkg::*; #(
    parameter int COLS           = DEFAULT_COLS,
    parameter int ROWS           = DEFAULT_ROWS,
    parameter int TICKS_PER_BIT  = DEFAULT_TICKS_PER_BIT,
    parameter int BASE_ON_CYCLES = DEFAULT_BASE_ON_CYCLES
) (
    input  logic                      clk_root,
    input  logic                      rst_n,
    input  logic                      uart_rxd,
    output logic [2:0]                rgb_top,
    output logic [2:0]                rgb_bottom,
    output logic [$clog2(ROWS/2)-1:0] row_addr,
    output logic                      pixel_clk,
    output logic                      row_latch,
    output logic                      output_enable_n
);
    localparam int ADDR_W = $clog2(COLS * ROWS);
    localparam int COL_W  = $clog2(COLS);
    localparam int ROW_W  = $clog2(ROWS / 2);

    logic [7:0]                 byte_data;
    logic                       byte_valid;
    logic [2:0]                 rgb_enable;
    logic [BRIGHTNESS_BITS-1:0] brightness_enable;

    fb_port_if #(.ADDR_W(ADDR_W)) wr_port ();
    fb_port_if #(.ADDR_W(ADDR_W)) rd_port ();
    pixel_load_if #(.COL_W(COL_W), .ROW_W(ROW_W)) load_if ();

    uart_rx #(.TICKS_PER_BIT(TICKS_PER_BIT)) i_uart_rx (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rxd        (uart_rxd),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    cmd_decoder #(.COLS(COLS), .ROWS(ROWS)) i_cmd_decoder (
        .clk_root          (clk_root),
        .rst_n             (rst_n),
        .byte_data         (byte_data),
        .byte_valid        (byte_valid),
        .wr_port           (wr_port.client),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer #(.COLS(COLS), .ROWS(ROWS)) i_framebuffer (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .wr_port  (wr_port.memory),
        .rd_port  (rd_port.memory)
    );

    pixel_fetch #(.COLS(COLS), .ROWS(ROWS)) i_pixel_fetch (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .scan     (load_if.fetch),
        .rd_port  (rd_port.client)
    );

    matrix_scan #(.COLS(COLS), .ROWS(ROWS), .BASE_ON_CYCLES(BASE_ON_CYCLES)) i_matrix_scan (
        .clk_root          (clk_root),
        .rst_n             (rst_n),
        .fetch             (load_if.scan),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom),
        .row_addr          (row_addr),
        .pixel_clk         (pixel_clk),
        .row_latch         (row_latch),
        .output_enable_n   (output_enable_n)
    );
endmodule

// ==== tb_led_matrix.sv ====
// testbench for the LED matrix driver
// random UART commands against a pixel model, panel outputs checked per row and plane
module tb_led_matrix import led_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLS          = 8;
    localparam int ROWS          = 8;
    localparam int TPB           = 4;
    localparam int BASE_ON       = 4;
    localparam int HALF          = ROWS / 2;
    localparam int N_EXTRA       = 16; // overwrites after the full fill
    localparam int N_MASK_ROUNDS = 3;
    localparam int N_JUNK        = 8;
    localparam int BYTE_CYCLES   = 12 * TPB; // start, 8 data, long stop
    localparam int FRAME_CYCLES  = HALF * BRIGHTNESS_BITS *
                                   (COLS * 12 + 4 + (BASE_ON << (BRIGHTNESS_BITS - 1)));
    localparam int TOTAL_BYTES   = (COLS * ROWS + N_EXTRA) * 4 + N_MASK_ROUNDS * 20 + 4 + N_JUNK * 5;
    // each display check waits at most four frames
    localparam int WATCHDOG_CYCLES = 200 + TOTAL_BYTES * BYTE_CYCLES +
                                     (N_MASK_ROUNDS + 2) * 4 * FRAME_CYCLES;

    logic                    clk_root;
    logic                    rst_n;
    logic                    uart_rxd;
    logic [2:0]              rgb_top;
    logic [2:0]              rgb_bottom;
    logic [$clog2(HALF)-1:0] row_addr;
    logic                    pixel_clk;
    logic                    row_latch;
    logic                    output_enable_n;

    int                         seed = 59586;
    pixel_t                     model [ROWS][COLS]; // [y][x]
    logic [2:0]                 rgb_en_m = '1;
    logic [BRIGHTNESS_BITS-1:0] bright_en_m = '1;
    logic [2:0]                 top_buf [COLS]; // shifted data since the last latch
    logic [2:0]                 bot_buf [COLS];
    int                         col_cnt;
    int                         plane;
    int                         on_cnt;
    int                         frame_cnt;
    int                         last_row;
    bit                         mon_en;
    bit                         cmp_en;
    bit                         seen_latch;

    led_matrix_top #(.COLS(COLS), .ROWS(ROWS), .TICKS_PER_BIT(TPB), .BASE_ON_CYCLES(BASE_ON))
        i_dut (.*);

    initial begin
        clk_root = 1'b0;
        forever #5 clk_root = ~clk_root;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic compare(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, expected);
            abort_run();
        end
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_root);
            uart_rxd <= frame[i];
            repeat (TPB - 1) @(posedge clk_root);
        end
        repeat (2 * TPB) @(posedge clk_root);
    endtask

    task automatic send_pixel(input logic [7:0] x, input logic [7:0] y, input logic [7:0] colour);
        send_byte(CMD_PIXEL);
        send_byte(x);
        send_byte(y);
        send_byte(colour);
        if (x < COLS && y < ROWS) begin
            model[y][x] = colour[5:0];
        end
    endtask

    task automatic send_mask(input logic [7:0] opcode, input logic [7:0] arg);
        send_byte(opcode);
        send_byte(arg);
        if (opcode == CMD_BRIGHTNESS) begin
            bright_en_m = arg[BRIGHTNESS_BITS-1:0];
        end else begin
            rgb_en_m = arg[2:0];
        end
    endtask

    // r, g, b bits of one plane, dark when the channel or plane is off
    function automatic logic [2:0] expected_rgb(input pixel_t px, input int pl);
        logic [2:0] lit;
        lit = {px.r[pl], px.g[pl], px.b[pl]};
        if (!bright_en_m[pl]) begin
            lit = 3'b000;
        end
        return lit & rgb_en_m;
    endfunction

    task automatic check_row(input int row, input int pl);
        for (int c = 0; c < COLS; c++) begin
            compare($sformatf("rgb_top col %0d row %0d plane %0d", c, row, pl),
                    top_buf[c], expected_rgb(model[row][c], pl));
            compare($sformatf("rgb_bottom col %0d row %0d plane %0d", c, row + HALF, pl),
                    bot_buf[c], expected_rgb(model[row + HALF][c], pl));
        end
    endtask

    // let two frames pass, then compare one full frame
    task automatic check_display();
        int start;
        start = frame_cnt;
        wait (frame_cnt >= start + 2);
        cmp_en = 1'b1;
        wait (frame_cnt >= start + 3);
        cmp_en = 1'b0;
    endtask

    // panel monitor, sampled mid cycle
    always @(negedge clk_root) begin
        if (mon_en) begin
            if (pixel_clk) begin
                compare("output_enable_n while shifting", output_enable_n, 1);
                if (col_cnt < COLS) begin
                    top_buf[col_cnt] = rgb_top;
                    bot_buf[col_cnt] = rgb_bottom;
                end
                col_cnt++;
            end
            if (row_latch) begin
                compare("output_enable_n at row_latch", output_enable_n, 1);
                compare("pixel_clk pulses per latch", col_cnt, COLS);
                if (!seen_latch) begin
                    compare("row_addr", row_addr, 0);
                    plane = 0;
                end else if (int'(row_addr) != last_row) begin
                    compare("latches per row", plane + 1, BRIGHTNESS_BITS);
                    compare("row_addr", row_addr, (last_row + 1) % HALF);
                    plane = 0;
                end else begin
                    plane++;
                    if (plane >= BRIGHTNESS_BITS) begin
                        compare("latches per row", plane + 1, BRIGHTNESS_BITS);
                    end
                end
                last_row   = row_addr;
                seen_latch = 1'b1;
                if (cmp_en) begin
                    check_row(row_addr, plane);
                end
                if (row_addr == 0 && plane == 0) begin
                    frame_cnt++; // new frame starts
                end
                col_cnt = 0;
            end
            if (!output_enable_n) begin
                on_cnt++;
            end else if (on_cnt != 0) begin
                compare($sformatf("output_enable_n low cycles plane %0d", plane),
                        on_cnt, BASE_ON << plane);
                on_cnt = 0;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_root);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        logic [7:0] op;
        rst_n    <= 1'b0;
        uart_rxd <= 1'b1;
        repeat (10) @(posedge clk_root);
        rst_n <= 1'b1;
        @(negedge clk_root);
        compare("pixel_clk", pixel_clk, 0);
        compare("row_latch", row_latch, 0);
        compare("output_enable_n", output_enable_n, 1);
        compare("row_addr", row_addr, 0);
        mon_en = 1'b1;

        // every pixel once, then random overwrites
        for (int y = 0; y < ROWS; y++) begin
            for (int x = 0; x < COLS; x++) begin
                send_pixel(8'(x), 8'(y), 8'($random(seed)));
            end
        end
        for (int i = 0; i < N_EXTRA; i++) begin
            send_pixel(8'({$random(seed)} % COLS), 8'({$random(seed)} % ROWS), 8'($random(seed)));
        end
        check_display();

        for (int r = 0; r < N_MASK_ROUNDS; r++) begin
            send_mask(CMD_BRIGHTNESS, 8'($random(seed)));
            send_mask(CMD_RGB_ENABLE, 8'($random(seed)));
            for (int i = 0; i < 4; i++) begin
                send_pixel(8'({$random(seed)} % COLS), 8'({$random(seed)} % ROWS),
                           8'($random(seed)));
            end
            check_display();
        end

        // unknown opcodes and off-panel pixels must not disturb the frame
        send_mask(CMD_BRIGHTNESS, 8'hff);
        send_mask(CMD_RGB_ENABLE, 8'hff);
        for (int i = 0; i < N_JUNK; i++) begin
            do begin
                op = 8'($random(seed));
            end while (op == CMD_PIXEL || op == CMD_BRIGHTNESS || op == CMD_RGB_ENABLE);
            send_byte(op);
            if (i % 2 == 0) begin
                send_pixel(8'(COLS + {$random(seed)} % (256 - COLS)), 8'({$random(seed)} % ROWS),
                           8'($random(seed)));
            end else begin
                send_pixel(8'({$random(seed)} % COLS), 8'(ROWS + {$random(seed)} % (256 - ROWS)),
                           8'($random(seed)));
            end
        end
        check_display();

        $display("Regression passed");
        $finish;
    end
endmodule

// ==== all.f ====
led_pkg.sv
fb_port_if.sv
pixel_load_if.sv
uart_rx.sv
cmd_decoder.sv
framebuffer.sv
pixel_fetch.sv
matrix_scan.sv
led_matrix_top.sv
tb_led_matrix.sv

// ==== Makefile ====
TOP := tb_led_matrix

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir -o sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

.PHONY: help test clean
